// File: rtl/exec_settings.svh
/*
 * exec slice settings
 * data width, register count and execute unit queue depths
 */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// --------------------------------------------------------------------------
// datapath
// --------------------------------------------------------------------------

// data and pc width
`define EXEC_XLEN 32
// architectural registers, x0 reads as zero
`define EXEC_NREGS 32

// --------------------------------------------------------------------------
// execute unit queues
// --------------------------------------------------------------------------

// queue depth doubles as the unit's initial credit count
`define EXEC_ALU_DEPTH 2
`define EXEC_BR_DEPTH 1

`endif

// File: rtl/exec_pkg.sv
/*
 * exec slice package
 * micro-ops, decode states and the issue and result message types
 */
`include "exec_settings.svh"

package exec_pkg;

  typedef logic [`EXEC_XLEN-1:0] word_t;
  typedef logic [$clog2(`EXEC_NREGS)-1:0] reg_addr_t;

  // micro-ops, alu group first then branch unit group
  typedef enum logic [3:0] {
    uop_add,
    uop_sub,
    uop_and,
    uop_or,
    uop_xor,
    uop_sll,
    uop_srl,
    uop_addi,
    uop_beq,
    uop_bne,
    uop_blt,
    uop_jal
  } uop_e;

  // decode issue control
  typedef enum logic [1:0] {
    dec_run,
    dec_wait_branch,
    dec_skip_wrong_path
  } dec_state_e;

  // decode to unit message
  typedef struct packed {
    word_t     pc;
    word_t     op1;
    word_t     op2;
    word_t     imm;
    reg_addr_t waddr;
    uop_e      uop;
  } issue_msg_t;

  // unit to merge message
  typedef struct packed {
    logic      wen;
    reg_addr_t waddr;
    word_t     data;
    logic      taken;
    word_t     target;
  } unit_result_t;

  // steering, true for ops handled by the branch unit
  function automatic logic is_branch_uop(uop_e uop);
    return uop inside {uop_beq, uop_bne, uop_blt, uop_jal};
  endfunction

endpackage

// File: rtl/exec_if.sv
/*
 * exec slice interfaces
 * credit-based issue, unit result and merged writeback buses
 */

// decode to execute unit, credit flows back
interface issue_if;
  logic                  val;
  exec_pkg::issue_msg_t  msg;
  // one pulse per entry leaving the unit queue
  logic                  credit;

  modport src (output val, msg, input credit);
  modport dst (input val, msg, output credit);
endinterface

// execute unit to merge, always accepted
interface result_if;
  logic                    val;
  exec_pkg::unit_result_t  res;

  modport src (output val, res);
  modport dst (input val, res);
endinterface

// merge back to decode
interface wb_if;
  logic                 wb_val;
  exec_pkg::reg_addr_t  wb_addr;
  exec_pkg::word_t      wb_data;
  // branch resolution, with or without a write
  logic                 br_done;
  logic                 br_taken;
  exec_pkg::word_t      br_target;

  modport src (
    output wb_val, wb_addr, wb_data, br_done, br_taken, br_target
  );
  modport dst (
    input wb_val, wb_addr, wb_data, br_done, br_taken, br_target
  );
endinterface

// File: rtl/decode_issue.sv
/*
 * decode and issue
 * register file, busy scoreboard, per-unit credits, wrong-path filter
 * and steering of packed issue messages to the alu or branch unit
 */
`include "exec_settings.svh"

module decode_issue (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_val,
  output logic                 in_rdy,
  input  exec_pkg::word_t      in_pc,
  input  exec_pkg::uop_e       in_uop,
  input  exec_pkg::reg_addr_t  in_rs1,
  input  exec_pkg::reg_addr_t  in_rs2,
  input  exec_pkg::reg_addr_t  in_rd,
  input  exec_pkg::word_t      in_imm,
  issue_if.src                 alu_iss,
  issue_if.src                 br_iss,
  wb_if.dst                    wb
);

  localparam int alu_cw = $clog2(`EXEC_ALU_DEPTH + 1);
  localparam int br_cw  = $clog2(`EXEC_BR_DEPTH + 1);

  exec_pkg::word_t       regs [`EXEC_NREGS];
  logic [`EXEC_NREGS-1:0] busy;
  logic [alu_cw-1:0]     alu_credits;
  logic [br_cw-1:0]      br_credits;
  exec_pkg::dec_state_e  state;
  exec_pkg::word_t       skip_target;
  exec_pkg::issue_msg_t  msg_q;
  logic                  alu_val_q;
  logic                  br_val_q;

  logic to_br, wrong_path, has_credit, iss_free, hazard;
  logic writes_rd, issue_ok, alu_send, br_send;

  // --------------------------------------------------------------------------
  // acceptance
  // --------------------------------------------------------------------------

  assign to_br      = exec_pkg::is_branch_uop(in_uop);
  // conditional branches never write
  assign writes_rd  = !to_br || (in_uop == exec_pkg::uop_jal);
  // off-target pcs are swallowed while skipping
  assign wrong_path = (state == exec_pkg::dec_skip_wrong_path) && (in_pc != skip_target);
  assign has_credit = to_br ? (br_credits != '0) : (alu_credits != '0);
  assign iss_free   = to_br ? !br_val_q : !alu_val_q;
  // busy[0] is never set so x0 needs no special case
  assign hazard     = busy[in_rs1] | busy[in_rs2] | busy[in_rd];

  assign in_rdy = (state != exec_pkg::dec_wait_branch) &&
                  (wrong_path || (has_credit && iss_free && !hazard));

  assign issue_ok = in_val && in_rdy && !wrong_path;
  assign alu_send = issue_ok && !to_br;
  assign br_send  = issue_ok && to_br;

  // --------------------------------------------------------------------------
  // register file and scoreboard
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (wb.wb_val && wb.wb_addr != '0) begin
      regs[wb.wb_addr] <= wb.wb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= '0;
    end else begin
      // clear first, a stalled rd can't be set in the same cycle anyway
      if (wb.wb_val) busy[wb.wb_addr] <= 1'b0;
      if (issue_ok && writes_rd && in_rd != '0) busy[in_rd] <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // issue registers, one message shared by both units
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (issue_ok) begin
      msg_q.pc    <= in_pc;
      msg_q.op1   <= (in_rs1 == '0) ? '0 : regs[in_rs1];
      // addi takes the immediate as second operand
      msg_q.op2   <= (in_uop == exec_pkg::uop_addi) ? in_imm :
                     (in_rs2 == '0) ? '0 : regs[in_rs2];
      msg_q.imm   <= in_imm;
      msg_q.waddr <= writes_rd ? in_rd : '0;
      msg_q.uop   <= in_uop;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      alu_val_q   <= 1'b0;
      br_val_q    <= 1'b0;
      alu_credits <= alu_cw'(`EXEC_ALU_DEPTH);
      br_credits  <= br_cw'(`EXEC_BR_DEPTH);
    end else begin
      alu_val_q   <= alu_send;
      br_val_q    <= br_send;
      // send and return in one cycle cancel out
      alu_credits <= alu_credits + alu_cw'(alu_iss.credit) - alu_cw'(alu_send);
      br_credits  <= br_credits + br_cw'(br_iss.credit) - br_cw'(br_send);
    end
  end

  assign alu_iss.val = alu_val_q;
  assign alu_iss.msg = msg_q;
  assign br_iss.val  = br_val_q;
  assign br_iss.msg  = msg_q;

  // --------------------------------------------------------------------------
  // branch control FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= exec_pkg::dec_run;
    end else begin
      case (state)
        exec_pkg::dec_wait_branch:
          if (wb.br_done) begin
            state <= wb.br_taken ? exec_pkg::dec_skip_wrong_path : exec_pkg::dec_run;
          end
        default:
          // run, or skip once the target pc shows up
          if (issue_ok) begin
            state <= to_br ? exec_pkg::dec_wait_branch : exec_pkg::dec_run;
          end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wb.br_done && wb.br_taken) skip_target <= wb.br_target;
  end

endmodule

// File: rtl/alu_unit.sv
/*
 * integer alu unit
 * ring-buffer input queue returning one credit per pop, then a
 * single-cycle execute stage into a registered result
 */
`include "exec_settings.svh"

module alu_unit (
  input  logic     clk,
  input  logic     reset,
  issue_if.dst     iss,
  result_if.src    res
);

  localparam int depth = `EXEC_ALU_DEPTH;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  exec_pkg::issue_msg_t   q [depth];
  logic [ptr_w-1:0]       wr_ptr;
  logic [ptr_w-1:0]       rd_ptr;
  logic [cnt_w-1:0]       cnt;
  logic                   pop;
  exec_pkg::issue_msg_t   head;
  exec_pkg::word_t        result;
  logic                   res_val_q;
  exec_pkg::unit_result_t res_q;

  // --------------------------------------------------------------------------
  // input queue
  // --------------------------------------------------------------------------

  // drains every cycle, no back-pressure downstream
  assign pop        = (cnt != '0);
  assign head       = q[rd_ptr];
  assign iss.credit = pop;

  always_ff @(posedge clk) begin
    if (iss.val) q[wr_ptr] <= iss.msg;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (iss.val) wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      cnt <= cnt + cnt_w'(iss.val) - cnt_w'(pop);
    end
  end

  // --------------------------------------------------------------------------
  // execute
  // --------------------------------------------------------------------------

  always_comb begin
    case (head.uop)
      exec_pkg::uop_add,
      exec_pkg::uop_addi: result = head.op1 + head.op2;
      exec_pkg::uop_sub:  result = head.op1 - head.op2;
      exec_pkg::uop_and:  result = head.op1 & head.op2;
      exec_pkg::uop_or:   result = head.op1 | head.op2;
      exec_pkg::uop_xor:  result = head.op1 ^ head.op2;
      // shift amount from op2[4:0]
      exec_pkg::uop_sll:  result = head.op1 << head.op2[4:0];
      exec_pkg::uop_srl:  result = head.op1 >> head.op2[4:0];
      default:            result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) res_val_q <= 1'b0;
    else       res_val_q <= pop;
  end

  always_ff @(posedge clk) begin
    res_q.wen    <= (head.waddr != '0);
    res_q.waddr  <= head.waddr;
    res_q.data   <= result;
    res_q.taken  <= 1'b0;
    res_q.target <= '0;
  end

  assign res.val = res_val_q;
  assign res.res = res_q;

endmodule

// File: rtl/branch_unit.sv
/*
 * branch and jump unit
 * shifting input queue with credit return, compare, target and link
 */
`include "exec_settings.svh"

module branch_unit (
  input  logic     clk,
  input  logic     reset,
  issue_if.dst     iss,
  result_if.src    res
);

  localparam int depth = `EXEC_BR_DEPTH;
  localparam int cnt_w = $clog2(depth + 1);

  exec_pkg::issue_msg_t   q [depth];
  logic [cnt_w-1:0]       cnt;
  logic                   pop;
  exec_pkg::issue_msg_t   head;
  logic                   taken;
  logic                   res_val_q;
  exec_pkg::unit_result_t res_q;

  // --------------------------------------------------------------------------
  // input queue, head always at slot 0
  // --------------------------------------------------------------------------

  assign pop        = (cnt != '0);
  assign head       = q[0];
  assign iss.credit = pop;

  always_ff @(posedge clk) begin
    for (int i = 0; i < depth - 1; i++) begin
      if (pop) q[i] <= q[i+1];
    end
    // lands behind whatever survives the pop
    if (iss.val) q[cnt - cnt_w'(pop)] <= iss.msg;
  end

  always_ff @(posedge clk) begin
    if (reset) cnt <= '0;
    else       cnt <= cnt + cnt_w'(iss.val) - cnt_w'(pop);
  end

  // --------------------------------------------------------------------------
  // resolve
  // --------------------------------------------------------------------------

  always_comb begin
    case (head.uop)
      exec_pkg::uop_beq: taken = (head.op1 == head.op2);
      exec_pkg::uop_bne: taken = (head.op1 != head.op2);
      exec_pkg::uop_blt: taken = ($signed(head.op1) < $signed(head.op2));
      exec_pkg::uop_jal: taken = 1'b1;
      default:           taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) res_val_q <= 1'b0;
    else       res_val_q <= pop;
  end

  always_ff @(posedge clk) begin
    // only jal links, decode zeroes waddr for the rest
    res_q.wen    <= (head.uop == exec_pkg::uop_jal) && (head.waddr != '0);
    res_q.waddr  <= head.waddr;
    res_q.data   <= head.pc + 32'd4;
    res_q.taken  <= taken;
    res_q.target <= head.pc + head.imm;
  end

  assign res.val = res_val_q;
  assign res.res = res_q;

endmodule

// File: rtl/result_merge.sv
/*
 * result merge
 * one registered writeback per cycle, alu first, a colliding branch
 * result waits in a one-entry hold register; raises the redirect
 */

module result_merge (
  input  logic                 clk,
  input  logic                 reset,
  result_if.dst                alu_res,
  result_if.dst                br_res,
  wb_if.src                    wb,
  output logic                 wb_val,
  output exec_pkg::reg_addr_t  wb_addr,
  output exec_pkg::word_t      wb_data,
  output logic                 redirect_val,
  output exec_pkg::word_t      redirect_target
);

  logic                    hold_val;
  exec_pkg::unit_result_t  hold_res;
  logic                    br_pend;
  exec_pkg::unit_result_t  br_cur;
  logic                    take_br;
  logic                    wb_val_q;
  exec_pkg::reg_addr_t     wb_addr_q;
  exec_pkg::word_t         wb_data_q;
  logic                    br_done_q;
  logic                    br_taken_q;
  exec_pkg::word_t         br_target_q;

  // held branch result goes ahead of a fresh one
  // only one branch in flight, so both never coexist
  assign br_pend = hold_val | br_res.val;
  assign br_cur  = hold_val ? hold_res : br_res.res;
  assign take_br = br_pend && !alu_res.val;

  // --------------------------------------------------------------------------
  // hold register
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) hold_val <= 1'b0;
    else       hold_val <= br_pend && alu_res.val;
  end

  always_ff @(posedge clk) begin
    if (br_pend && alu_res.val) hold_res <= br_cur;
  end

  // --------------------------------------------------------------------------
  // writeback and branch resolution
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_val_q   <= 1'b0;
      br_done_q  <= 1'b0;
      br_taken_q <= 1'b0;
    end else begin
      wb_val_q   <= alu_res.val ? alu_res.res.wen : (take_br && br_cur.wen);
      br_done_q  <= take_br;
      br_taken_q <= take_br && br_cur.taken;
    end
  end

  always_ff @(posedge clk) begin
    wb_addr_q   <= alu_res.val ? alu_res.res.waddr : br_cur.waddr;
    wb_data_q   <= alu_res.val ? alu_res.res.data : br_cur.data;
    br_target_q <= br_cur.target;
  end

  assign wb.wb_val    = wb_val_q;
  assign wb.wb_addr   = wb_addr_q;
  assign wb.wb_data   = wb_data_q;
  assign wb.br_done   = br_done_q;
  assign wb.br_taken  = br_taken_q;
  assign wb.br_target = br_target_q;

  assign wb_val          = wb_val_q;
  assign wb_addr         = wb_addr_q;
  assign wb_data         = wb_data_q;
  // redirect pulses with the branch's own writeback
  assign redirect_val    = br_taken_q;
  assign redirect_target = br_target_q;

endmodule

// File: rtl/exec_core.sv
/*
 * decode-to-execute slice top
 * decode/issue feeding the alu and branch units, merged writeback
 */

module exec_core (
  input  logic                 clk,
  input  logic                 reset,
  // instruction input, valid/ready
  input  logic                 in_val,
  output logic                 in_rdy,
  input  exec_pkg::word_t      in_pc,
  input  exec_pkg::uop_e       in_uop,
  input  exec_pkg::reg_addr_t  in_rs1,
  input  exec_pkg::reg_addr_t  in_rs2,
  input  exec_pkg::reg_addr_t  in_rd,
  input  exec_pkg::word_t      in_imm,
  // writeback and redirect pulses
  output logic                 wb_val,
  output exec_pkg::reg_addr_t  wb_addr,
  output exec_pkg::word_t      wb_data,
  output logic                 redirect_val,
  output exec_pkg::word_t      redirect_target
);

  issue_if  alu_iss ();
  issue_if  br_iss ();
  result_if alu_res ();
  result_if br_res ();
  wb_if     wb_bus ();

  decode_issue u_decode_issue (
    .clk     (clk),
    .reset   (reset),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .in_pc   (in_pc),
    .in_uop  (in_uop),
    .in_rs1  (in_rs1),
    .in_rs2  (in_rs2),
    .in_rd   (in_rd),
    .in_imm  (in_imm),
    .alu_iss (alu_iss.src),
    .br_iss  (br_iss.src),
    .wb      (wb_bus.dst)
  );

  alu_unit u_alu_unit (
    .clk   (clk),
    .reset (reset),
    .iss   (alu_iss.dst),
    .res   (alu_res.src)
  );

  branch_unit u_branch_unit (
    .clk   (clk),
    .reset (reset),
    .iss   (br_iss.dst),
    .res   (br_res.src)
  );

  result_merge u_result_merge (
    .clk             (clk),
    .reset           (reset),
    .alu_res         (alu_res.dst),
    .br_res          (br_res.dst),
    .wb              (wb_bus.src),
    .wb_val          (wb_val),
    .wb_addr         (wb_addr),
    .wb_data         (wb_data),
    .redirect_val    (redirect_val),
    .redirect_target (redirect_target)
  );

endmodule

// File: testbench/exec_core_chk.sv
/*
 * exec core checker
 * concurrent assertions on decode credits, writeback and redirect
 */
`include "exec_settings.svh"

module exec_core_chk (
  input logic                                   clk,
  input logic                                   reset,
  input logic [$clog2(`EXEC_ALU_DEPTH + 1)-1:0] alu_credits,
  input logic [$clog2(`EXEC_BR_DEPTH + 1)-1:0]  br_credits,
  input logic                                   alu_credit,
  input logic                                   br_credit,
  input exec_pkg::dec_state_e                   state,
  input logic                                   wb_val,
  input exec_pkg::reg_addr_t                    wb_addr,
  input logic                                   redirect_val
);

  // ------------------------------------------------------------------------
  // credits stay within 0..depth
  // ------------------------------------------------------------------------

  a_alu_credit_max: assert property (@(posedge clk) disable iff (reset)
    alu_credits <= `EXEC_ALU_DEPTH) else $error("alu credits above queue depth");
  // a unit only hands back credits that decode spent
  // an underflow leaves the counter one high, so a later return trips these too
  a_alu_credit_ret: assert property (@(posedge clk) disable iff (reset)
    alu_credit |-> alu_credits < `EXEC_ALU_DEPTH)
    else $error("alu credit returned with counter full");
  a_br_credit_ret: assert property (@(posedge clk) disable iff (reset)
    br_credit |-> br_credits < `EXEC_BR_DEPTH)
    else $error("branch credit returned with counter full");

  // ------------------------------------------------------------------------
  // writeback and redirect
  // ------------------------------------------------------------------------

  a_wb_nonzero: assert property (@(posedge clk) disable iff (reset)
    wb_val |-> wb_addr != '0) else $error("writeback to x0");
  // only the single in-flight branch can redirect
  a_redirect_state: assert property (@(posedge clk) disable iff (reset)
    redirect_val |-> state == exec_pkg::dec_wait_branch)
    else $error("redirect outside wait_branch");

endmodule

bind decode_issue exec_core_chk u_exec_core_chk (
  .clk          (clk),
  .reset        (reset),
  .alu_credits  (alu_credits),
  .br_credits   (br_credits),
  .alu_credit   (alu_iss.credit),
  .br_credit    (br_iss.credit),
  .state        (state),
  .wb_val       (wb.wb_val),
  .wb_addr      (wb.wb_addr),
  .redirect_val (wb.br_taken)
);

// File: testbench/exec_core_tb.sv
/*
 * exec core testbench
 * directed tests checked against a register model with one pending
 * write per rd and a queue of expected redirect targets
 */
`include "exec_settings.svh"

module exec_core_tb;

  // about 45 instructions at under 10 cycles each, so 4000 is ample
  localparam int max_cycles = 4000;

  logic                clk;
  logic                reset;
  logic                in_val;
  logic                in_rdy;
  exec_pkg::word_t     in_pc;
  exec_pkg::uop_e      in_uop;
  exec_pkg::reg_addr_t in_rs1;
  exec_pkg::reg_addr_t in_rs2;
  exec_pkg::reg_addr_t in_rd;
  exec_pkg::word_t     in_imm;
  logic                wb_val;
  exec_pkg::reg_addr_t wb_addr;
  exec_pkg::word_t     wb_data;
  logic                redirect_val;
  exec_pkg::word_t     redirect_target;

  // reference model
  exec_pkg::word_t ref_regs [`EXEC_NREGS];
  logic            pend_val [`EXEC_NREGS];
  exec_pkg::word_t pend_data [`EXEC_NREGS];
  exec_pkg::word_t redirect_q [$];
  exec_pkg::word_t exp_target;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int wb_seen = 0;
  int cycles = 0;

  exec_core u_exec_core (
    .clk             (clk),
    .reset           (reset),
    .in_val          (in_val),
    .in_rdy          (in_rdy),
    .in_pc           (in_pc),
    .in_uop          (in_uop),
    .in_rs1          (in_rs1),
    .in_rs2          (in_rs2),
    .in_rd           (in_rd),
    .in_imm          (in_imm),
    .wb_val          (wb_val),
    .wb_addr         (wb_addr),
    .wb_data         (wb_data),
    .redirect_val    (redirect_val),
    .redirect_target (redirect_target)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // output monitor, sampled mid-cycle
  // --------------------------------------------------------------------------

  always @(negedge clk) begin
    if (!reset && wb_val) begin
      wb_seen++;
      if (!pend_val[wb_addr]) begin
        $display("%0t: writeback to x%0d with no write pending for it", $time, wb_addr);
        errors++;
      end else begin
        checks++;
        if (wb_data !== pend_data[wb_addr]) begin
          $display("CHECK FAILED %0t: x%0d written %h, expected %h",
                   $time, wb_addr, wb_data, pend_data[wb_addr]);
          errors++;
        end
        pend_val[wb_addr] = 1'b0;
      end
    end
    if (!reset && redirect_val) begin
      if (redirect_q.size() == 0) begin
        $display("%0t: redirect to %h with no taken branch outstanding",
                 $time, redirect_target);
        errors++;
      end else begin
        checks++;
        exp_target = redirect_q.pop_front();
        if (redirect_target !== exp_target) begin
          $display("CHECK FAILED %0t: redirect to %h, expected %h",
                   $time, redirect_target, exp_target);
          errors++;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // model rules
  // --------------------------------------------------------------------------

  function automatic exec_pkg::word_t alu_expect(exec_pkg::uop_e uop,
                                                 exec_pkg::word_t a, exec_pkg::word_t b);
    case (uop)
      exec_pkg::uop_add, exec_pkg::uop_addi: return a + b;
      exec_pkg::uop_sub: return a - b;
      exec_pkg::uop_and: return a & b;
      exec_pkg::uop_or:  return a | b;
      exec_pkg::uop_xor: return a ^ b;
      // shift amount is op2[4:0]
      exec_pkg::uop_sll: return a << b[4:0];
      exec_pkg::uop_srl: return a >> b[4:0];
      default:           return '0;
    endcase
  endfunction

  function automatic bit branch_taken(exec_pkg::uop_e uop,
                                      exec_pkg::word_t a, exec_pkg::word_t b);
    case (uop)
      exec_pkg::uop_beq: return a == b;
      exec_pkg::uop_bne: return a != b;
      exec_pkg::uop_blt: return $signed(a) < $signed(b);
      default:           return 1'b1;
    endcase
  endfunction

  // offer one instruction, wait for the handshake, update the model if live
  task automatic send_instr(input exec_pkg::word_t pc, input exec_pkg::uop_e uop,
                            input exec_pkg::reg_addr_t rs1, input exec_pkg::reg_addr_t rs2,
                            input exec_pkg::reg_addr_t rd, input exec_pkg::word_t imm,
                            input bit live);
    exec_pkg::word_t a;
    exec_pkg::word_t b;
    exec_pkg::word_t v;
    a = ref_regs[rs1];
    b = (uop == exec_pkg::uop_addi) ? imm : ref_regs[rs2];
    in_val = 1'b1;
    in_pc  = pc;
    in_uop = uop;
    in_rs1 = rs1;
    in_rs2 = rs2;
    in_rd  = rd;
    in_imm = imm;
    @(negedge clk);
    while (!in_rdy) @(negedge clk);
    @(posedge clk);
    #2;
    in_val = 1'b0;
    if (live) begin
      if (uop inside {exec_pkg::uop_beq, exec_pkg::uop_bne, exec_pkg::uop_blt,
                      exec_pkg::uop_jal}) begin
        if (branch_taken(uop, a, b)) redirect_q.push_back(pc + imm);
        v = pc + 32'd4;
      end else begin
        v = alu_expect(uop, a, b);
      end
      // conditional branches and x0 never write
      if (rd != '0 && !(uop inside {exec_pkg::uop_beq, exec_pkg::uop_bne,
                                    exec_pkg::uop_blt})) begin
        ref_regs[rd]  = v;
        pend_val[rd]  = 1'b1;
        pend_data[rd] = v;
      end
    end
  endtask

  // wait until every expected write and redirect has been seen
  task automatic wait_drain();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      #1;
      busy = (redirect_q.size() != 0);
      for (int i = 0; i < `EXEC_NREGS; i++) begin
        if (pend_val[i]) busy = 1'b1;
      end
    end
    // idle a little so a stray late writeback is still caught
    repeat (4) @(negedge clk);
    @(posedge clk);
    #2;
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    $display("test %-14s %s, %0d errors", name,
             (errors == errs_before) ? "passed" : "failed", errors - errs_before);
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------

  task automatic alu_ops_test();
    exec_pkg::uop_e ops [8];
    int e0;
    e0 = errors;
    ops = '{exec_pkg::uop_add, exec_pkg::uop_sub, exec_pkg::uop_and, exec_pkg::uop_or,
            exec_pkg::uop_xor, exec_pkg::uop_sll, exec_pkg::uop_srl, exec_pkg::uop_addi};
    // random seeds into x1..x8 through addi from x0
    for (int i = 1; i <= 8; i++) begin
      send_instr(32'(4 * i), exec_pkg::uop_addi, '0, '0,
                 exec_pkg::reg_addr_t'(i), $urandom(), 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      send_instr(32'h40 + 32'(4 * i), ops[i],
                 exec_pkg::reg_addr_t'(1 + $urandom_range(7)),
                 ops[i] == exec_pkg::uop_addi ? '0 :
                 exec_pkg::reg_addr_t'(1 + $urandom_range(7)),
                 exec_pkg::reg_addr_t'(10 + i), $urandom(), 1'b1);
    end
    wait_drain();
    report_test("alu_ops", e0);
  endtask

  task automatic dep_chain_test();
    int e0;
    e0 = errors;
    // each op reads the rd just written
    send_instr(32'h80, exec_pkg::uop_add, 5'd1, 5'd2, 5'd20, '0, 1'b1);
    send_instr(32'h84, exec_pkg::uop_sub, 5'd20, 5'd3, 5'd21, '0, 1'b1);
    send_instr(32'h88, exec_pkg::uop_xor, 5'd21, 5'd20, 5'd22, '0, 1'b1);
    send_instr(32'h8c, exec_pkg::uop_sll, 5'd22, 5'd4, 5'd23, '0, 1'b1);
    send_instr(32'h90, exec_pkg::uop_addi, 5'd23, 5'd0, 5'd23, 32'h55, 1'b1);
    // rewrite of x20 waits on its own busy bit
    send_instr(32'h94, exec_pkg::uop_or, 5'd23, 5'd22, 5'd20, '0, 1'b1);
    wait_drain();
    report_test("dep_chain", e0);
  endtask

  task automatic credit_burst_test();
    int e0;
    int seen0;
    e0 = errors;
    seen0 = wb_seen;
    for (int i = 0; i < 3 * `EXEC_ALU_DEPTH; i++) begin
      send_instr(32'hc0 + 32'(4 * i), exec_pkg::uop_addi, '0, '0,
                 exec_pkg::reg_addr_t'(24 + i), $urandom(), 1'b1);
    end
    wait_drain();
    checks++;
    if (wb_seen - seen0 != 3 * `EXEC_ALU_DEPTH) begin
      $display("CHECK FAILED %0t: burst saw %0d writebacks, expected %0d",
               $time, wb_seen - seen0, 3 * `EXEC_ALU_DEPTH);
      errors++;
    end
    report_test("credit_burst", e0);
  endtask

  task automatic taken_branch_test();
    int e0;
    e0 = errors;
    send_instr(32'hf0, exec_pkg::uop_addi, '0, '0, 5'd5, 32'd7, 1'b1);
    send_instr(32'hf4, exec_pkg::uop_addi, '0, '0, 5'd6, 32'd7, 1'b1);
    send_instr(32'hf8, exec_pkg::uop_addi, '0, '0, 5'd7, 32'hffff_fffd, 1'b1);
    send_instr(32'hfc, exec_pkg::uop_addi, '0, '0, 5'd8, 32'd5, 1'b1);
    // beq equal, target 0x140, two wrong-path ops dropped
    send_instr(32'h100, exec_pkg::uop_beq, 5'd5, 5'd6, '0, 32'h40, 1'b1);
    send_instr(32'h104, exec_pkg::uop_addi, '0, '0, 5'd9, 32'h11, 1'b0);
    send_instr(32'h108, exec_pkg::uop_add, 5'd1, 5'd2, 5'd9, '0, 1'b0);
    send_instr(32'h140, exec_pkg::uop_addi, '0, '0, 5'd9, 32'h22, 1'b1);
    // blt -3 < 5, backward target 0x124
    send_instr(32'h144, exec_pkg::uop_blt, 5'd7, 5'd8, '0, 32'hffff_ffe0, 1'b1);
    send_instr(32'h148, exec_pkg::uop_addi, '0, '0, 5'd10, 32'h33, 1'b0);
    send_instr(32'h124, exec_pkg::uop_addi, '0, '0, 5'd10, 32'h44, 1'b1);
    wait_drain();
    report_test("taken_branch", e0);
  endtask

  task automatic not_taken_test();
    int e0;
    e0 = errors;
    // x5 equals x6, so no redirect
    send_instr(32'h200, exec_pkg::uop_bne, 5'd5, 5'd6, '0, 32'h80, 1'b1);
    send_instr(32'h204, exec_pkg::uop_addi, 5'd5, '0, 5'd11, 32'h3, 1'b1);
    wait_drain();
    report_test("not_taken", e0);
  endtask

  task automatic jal_test();
    int e0;
    e0 = errors;
    // link into x12, then a jal to x0 with no write
    send_instr(32'h300, exec_pkg::uop_jal, '0, '0, 5'd12, 32'h100, 1'b1);
    send_instr(32'h304, exec_pkg::uop_addi, '0, '0, 5'd13, 32'h1, 1'b0);
    send_instr(32'h400, exec_pkg::uop_jal, '0, '0, '0, 32'hffff_ff80, 1'b1);
    send_instr(32'h404, exec_pkg::uop_addi, '0, '0, 5'd13, 32'h2, 1'b0);
    send_instr(32'h380, exec_pkg::uop_addi, 5'd12, '0, 5'd13, 32'h10, 1'b1);
    wait_drain();
    report_test("jal", e0);
  endtask

  initial begin
    in_val = 1'b0;
    in_pc  = '0;
    in_uop = exec_pkg::uop_add;
    in_rs1 = '0;
    in_rs2 = '0;
    in_rd  = '0;
    in_imm = '0;
    for (int i = 0; i < `EXEC_NREGS; i++) begin
      ref_regs[i]  = '0;
      pend_val[i]  = 1'b0;
      pend_data[i] = '0;
    end
    void'($urandom(32'h31f));
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
    alu_ops_test();
    dep_chain_test();
    credit_burst_test();
    taken_branch_test();
    not_taken_test();
    jal_test();
    $display("summary: %0d tests, %0d checks, %0d writebacks, %0d errors",
             tests, checks, wb_seen, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+rtl
rtl/exec_pkg.sv
rtl/exec_if.sv
rtl/decode_issue.sv
rtl/alu_unit.sv
rtl/branch_unit.sv
rtl/result_merge.sv
rtl/exec_core.sv
testbench/exec_core_chk.sv
testbench/exec_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= exec_core_tb
LINT_TOP  ?= exec_core
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || { echo "run ended early, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(LINT_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
